// File: source/haar_stage_pkg.sv
package haar_stage_pkg;

	// Database geometry of one stage.
	localparam int WORD_WIDTH                = 12;
	localparam int INDEX_WIDTH               = 12;
	localparam int NUM_CLASSIFIERS           = 2;
	localparam int NUM_PARAMS_PER_CLASSIFIER = 19;
	localparam int NUM_HEADER_WORDS          = 3;
	localparam int NUM_PARAM_WORDS           = NUM_CLASSIFIERS * NUM_PARAMS_PER_CLASSIFIER;
	localparam int NUM_DATABASE_WORDS        = NUM_PARAM_WORDS + NUM_HEADER_WORDS;
	localparam int ADDR_WIDTH                = 6;

	localparam DATABASE_FILE = "stage_database.mem";

	// Header slots, in database order after the parameters.
	localparam logic [1:0] SLOT_THRESHOLD = 2'd0;
	localparam logic [1:0] SLOT_PARENT    = 2'd1;
	localparam logic [1:0] SLOT_NEXT      = 2'd2;

	// One streamed classifier parameter.
	typedef struct packed {
		logic [WORD_WIDTH-1:0]  data;
		logic [INDEX_WIDTH-1:0] index_tree;
		logic [INDEX_WIDTH-1:0] index_param;
		logic [INDEX_WIDTH-1:0] index_database;
		logic                   last_param;
		logic                   last_tree;
	} param_beat_t;

	// Single-cycle write of one header word.
	typedef struct packed {
		logic                  valid;
		logic [1:0]            slot;
		logic [WORD_WIDTH-1:0] data;
	} header_write_t;

	typedef struct packed {
		logic [WORD_WIDTH-1:0] threshold;
		logic [WORD_WIDTH-1:0] parent;
		logic [WORD_WIDTH-1:0] next;
	} stage_header_t;

endpackage

// File: source/stage_rom.sv
`timescale 1ns/1ps

module stage_rom
	import haar_stage_pkg::*;
(
	input  logic                  clk_fpga,
	input  logic                  i_rom_en,
	input  logic [ADDR_WIDTH-1:0] i_rom_addr,
	output logic [WORD_WIDTH-1:0] o_rom_data
);

	logic [WORD_WIDTH-1:0] rom_mem [NUM_DATABASE_WORDS];

	// Classifier parameters first, then threshold, parent and next.
	initial
	begin
		$readmemh(DATABASE_FILE, rom_mem);
	end

	// Read data holds between enabled cycles.
	always_ff @(posedge clk_fpga)
	begin
		if (i_rom_en)
		begin
			o_rom_data <= rom_mem[i_rom_addr];
		end
	end

endmodule

// File: source/stage_param_streamer.sv
`timescale 1ns/1ps

module stage_param_streamer
	import haar_stage_pkg::*;
(
	input  logic                  clk_fpga,
	input  logic                  reset_logic,
	input  logic                  i_start,
	input  logic [WORD_WIDTH-1:0] i_rom_data,
	input  logic                  i_param_ready,
	input  logic                  i_header_complete,
	output logic                  o_rom_en,
	output logic [ADDR_WIDTH-1:0] o_rom_addr,
	output param_beat_t           o_param,
	output logic                  o_param_valid,
	output header_write_t         o_header_wr,
	output logic                  o_busy
);

	// Travels alongside each read until its word returns.
	typedef struct packed {
		logic                   is_header;
		logic [1:0]             slot;
		logic [INDEX_WIDTH-1:0] index_tree;
		logic [INDEX_WIDTH-1:0] index_param;
		logic [INDEX_WIDTH-1:0] index_database;
		logic                   last_param;
		logic                   last_tree;
	} read_tag_t;

	logic                   busy_q;
	logic                   busy_end;
	logic                   start_accept;
	logic                   rd_active;
	logic [ADDR_WIDTH-1:0]  rd_addr;
	logic                   rd_is_param;
	logic                   rd_last;
	logic [INDEX_WIDTH-1:0] tree_cnt;
	logic [INDEX_WIDTH-1:0] param_cnt;
	logic                   end_classifier;
	logic                   end_tree;
	logic                   tag_valid;
	read_tag_t              tag;
	param_beat_t            push_beat;
	param_beat_t            buf_mem [2];
	logic                   buf_wr_ptr;
	logic                   buf_rd_ptr;
	logic [1:0]             buf_count;
	logic [1:0]             buf_occupancy;
	logic                   push;
	logic                   pop;
	logic                   room;
	header_write_t          hdr_ret;
	header_write_t          hdr_pend;
	logic                   hdr_hold;

	assign busy_end     = busy_q && i_header_complete && (buf_count == 2'd0);
	assign o_busy       = busy_q && !busy_end;
	assign start_accept = i_start && !o_busy;

	assign rd_is_param    = rd_addr < ADDR_WIDTH'(NUM_PARAM_WORDS);
	assign rd_last        = rd_addr == ADDR_WIDTH'(NUM_DATABASE_WORDS - 1);
	assign end_classifier = param_cnt == INDEX_WIDTH'(NUM_PARAMS_PER_CLASSIFIER - 1);
	assign end_tree       = end_classifier && (tree_cnt == INDEX_WIDTH'(NUM_CLASSIFIERS - 1));

	// Words held after this edge, counting the one coming back from memory.
	assign push          = tag_valid && !tag.is_header;
	assign pop           = o_param_valid && i_param_ready;
	assign buf_occupancy = buf_count + {1'b0, push} - {1'b0, pop};
	assign room          = buf_occupancy < 2'd2;

	// Header reads need no buffer space.
	assign o_rom_en   = rd_active && (!rd_is_param || room);
	assign o_rom_addr = rd_addr;

	always_ff @(posedge clk_fpga)
	begin
		if (reset_logic)
		begin
			busy_q    <= 1'b0;
			rd_active <= 1'b0;
			rd_addr   <= '0;
			tree_cnt  <= '0;
			param_cnt <= '0;
		end
		else if (start_accept)
		begin
			busy_q    <= 1'b1;
			rd_active <= 1'b1;
			rd_addr   <= '0;
			tree_cnt  <= '0;
			param_cnt <= '0;
		end
		else
		begin
			if (busy_end)
			begin
				busy_q <= 1'b0;
			end
			if (o_rom_en)
			begin
				rd_active <= !rd_last;
				rd_addr   <= rd_addr + 1'b1;
				if (rd_is_param)
				begin
					if (end_classifier)
					begin
						param_cnt <= '0;
						tree_cnt  <= end_tree ? '0 : tree_cnt + 1'b1;
					end
					else
					begin
						param_cnt <= param_cnt + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk_fpga)
	begin
		if (reset_logic)
		begin
			tag_valid <= 1'b0;
		end
		else
		begin
			tag_valid <= o_rom_en;
		end
	end

	always_ff @(posedge clk_fpga)
	begin
		if (o_rom_en)
		begin
			tag.is_header      <= !rd_is_param;
			tag.slot           <= 2'(rd_addr - ADDR_WIDTH'(NUM_PARAM_WORDS));
			tag.index_tree     <= tree_cnt;
			tag.index_param    <= param_cnt;
			tag.index_database <= INDEX_WIDTH'(rd_addr);
			tag.last_param     <= end_classifier;
			tag.last_tree      <= end_tree;
		end
	end

	always_comb
	begin
		push_beat.data           = i_rom_data;
		push_beat.index_tree     = tag.index_tree;
		push_beat.index_param    = tag.index_param;
		push_beat.index_database = tag.index_database;
		push_beat.last_param     = tag.last_param;
		push_beat.last_tree      = tag.last_tree;
	end

	always_ff @(posedge clk_fpga)
	begin
		if (push)
		begin
			buf_mem[buf_wr_ptr] <= push_beat;
		end
	end

	always_ff @(posedge clk_fpga)
	begin
		if (reset_logic)
		begin
			buf_wr_ptr <= 1'b0;
			buf_rd_ptr <= 1'b0;
			buf_count  <= 2'd0;
		end
		else
		begin
			if (push)
			begin
				buf_wr_ptr <= !buf_wr_ptr;
			end
			if (pop)
			begin
				buf_rd_ptr <= !buf_rd_ptr;
			end
			buf_count <= buf_count + {1'b0, push} - {1'b0, pop};
		end
	end

	assign o_param       = buf_mem[buf_rd_ptr];
	assign o_param_valid = buf_count != 2'd0;

	always_comb
	begin
		hdr_ret.valid = tag_valid && tag.is_header;
		hdr_ret.slot  = tag.slot;
		hdr_ret.data  = i_rom_data;
	end

	// The last header word waits for the stream to drain, so the stage
	// completes only once every beat has left.
	assign hdr_hold = hdr_ret.valid && (hdr_ret.slot == SLOT_NEXT) && (buf_count != 2'd0);

	always_ff @(posedge clk_fpga)
	begin
		if (reset_logic)
		begin
			hdr_pend <= '0;
		end
		else if (hdr_hold)
		begin
			hdr_pend <= hdr_ret;
		end
		else if (hdr_pend.valid && (buf_count == 2'd0))
		begin
			hdr_pend.valid <= 1'b0;
		end
	end

	always_comb
	begin
		if (hdr_pend.valid)
		begin
			o_header_wr       = hdr_pend;
			o_header_wr.valid = buf_count == 2'd0;
		end
		else
		begin
			o_header_wr       = hdr_ret;
			o_header_wr.valid = hdr_ret.valid && !hdr_hold;
		end
	end

endmodule

// File: source/stage_header_regs.sv
`timescale 1ns/1ps

module stage_header_regs
	import haar_stage_pkg::*;
(
	input  logic          clk_fpga,
	input  logic          reset_logic,
	input  logic          i_start,
	input  header_write_t i_header_wr,
	output stage_header_t o_header,
	output logic          o_header_complete
);

	logic [NUM_HEADER_WORDS-1:0] slot_mask;

	always_ff @(posedge clk_fpga)
	begin
		if (reset_logic)
		begin
			o_header  <= '0;
			slot_mask <= '0;
		end
		else
		begin
			// A start while a stage is still loading is ignored upstream.
			if (i_start && o_header_complete)
			begin
				slot_mask <= '0;
			end
			if (i_header_wr.valid)
			begin
				case (i_header_wr.slot)
					SLOT_THRESHOLD:
					begin
						o_header.threshold <= i_header_wr.data;
						slot_mask[0]       <= 1'b1;
					end
					SLOT_PARENT:
					begin
						o_header.parent <= i_header_wr.data;
						slot_mask[1]    <= 1'b1;
					end
					SLOT_NEXT:
					begin
						o_header.next <= i_header_wr.data;
						slot_mask[2]  <= 1'b1;
					end
					default:
					begin
					end
				endcase
			end
		end
	end

	assign o_header_complete = &slot_mask;

endmodule

// File: source/haar_stage_fetch_top.sv
`timescale 1ns/1ps

module haar_stage_fetch_top
	import haar_stage_pkg::*;
(
	input  logic          clk_fpga,
	input  logic          reset_logic,
	input  logic          i_start,
	input  logic          i_param_ready,
	output param_beat_t   o_param,
	output logic          o_param_valid,
	output stage_header_t o_header,
	output logic          o_stage_done,
	output logic          o_busy
);

	logic                  rom_en;
	logic [ADDR_WIDTH-1:0] rom_addr;
	logic [WORD_WIDTH-1:0] rom_data;
	header_write_t         header_wr;

	stage_rom u_stage_rom (
		.clk_fpga   (clk_fpga),
		.i_rom_en   (rom_en),
		.i_rom_addr (rom_addr),
		.o_rom_data (rom_data)
	);

	stage_param_streamer u_stage_param_streamer (
		.clk_fpga          (clk_fpga),
		.reset_logic       (reset_logic),
		.i_start           (i_start),
		.i_rom_data        (rom_data),
		.i_param_ready     (i_param_ready),
		.i_header_complete (o_stage_done),
		.o_rom_en          (rom_en),
		.o_rom_addr        (rom_addr),
		.o_param           (o_param),
		.o_param_valid     (o_param_valid),
		.o_header_wr       (header_wr),
		.o_busy            (o_busy)
	);

	// Header completion doubles as the stage done flag.
	stage_header_regs u_stage_header_regs (
		.clk_fpga          (clk_fpga),
		.reset_logic       (reset_logic),
		.i_start           (i_start),
		.i_header_wr       (header_wr),
		.o_header          (o_header),
		.o_header_complete (o_stage_done)
	);

endmodule

// File: sim/haar_stage_fetch_properties.sv
`timescale 1ns/1ps

module haar_stage_fetch_properties
	import haar_stage_pkg::*;
(
	input logic          clk_fpga,
	input logic          reset_logic,
	input logic          i_start,
	input logic          i_param_ready,
	input param_beat_t   o_param,
	input logic          o_param_valid,
	input stage_header_t o_header,
	input logic          o_stage_done,
	input logic          o_busy
);

	int failure_count = 0;

	// Synchronous reset leaves every output idle on the next cycle.
	reset_idle: assert property (@(posedge clk_fpga)
		reset_logic |=> !o_param_valid && !o_busy && !o_stage_done && (o_header == '0))
	else
	begin
		$error("Outputs not idle after reset");
		failure_count++;
	end

	// A stalled beat must not move or vanish.
	stall_holds: assert property (@(posedge clk_fpga) disable iff (reset_logic)
		o_param_valid && !i_param_ready |=> o_param_valid && $stable(o_param))
	else
	begin
		$error("o_param or o_param_valid changed while stalled");
		failure_count++;
	end

	valid_within_busy: assert property (@(posedge clk_fpga) disable iff (reset_logic)
		o_param_valid |-> o_busy)
	else
	begin
		$error("o_param_valid high outside a busy fetch");
		failure_count++;
	end

	// Done means the stream has drained.
	done_is_idle: assert property (@(posedge clk_fpga) disable iff (reset_logic)
		o_stage_done |-> !o_busy && !o_param_valid)
	else
	begin
		$error("o_stage_done high while busy or streaming");
		failure_count++;
	end

	done_holds: assert property (@(posedge clk_fpga) disable iff (reset_logic)
		o_stage_done && !i_start |=> o_stage_done)
	else
	begin
		$error("o_stage_done dropped without a start");
		failure_count++;
	end

	start_raises_busy: assert property (@(posedge clk_fpga) disable iff (reset_logic)
		i_start && !o_busy |=> o_busy)
	else
	begin
		$error("Accepted start did not raise o_busy");
		failure_count++;
	end

endmodule

// File: sim/tb_haar_stage_fetch.sv
`timescale 1ns/1ps

module tb_haar_stage_fetch
	import haar_stage_pkg::*;
();

	localparam int          CLK_PERIOD          = 10;
	localparam int          RESET_CYCLES        = 2;
	localparam logic [31:0] RANDOM_SEED         = 32'he537_d6bf;
	localparam int          FIRST_VALID_LATENCY = 2;
	localparam int          FETCH_MARGIN        = 24;
	localparam int          FETCH_CYCLES        = NUM_DATABASE_WORDS + FETCH_MARGIN;
	localparam int          WATCHDOG_NS         = 4 * (2 * FETCH_CYCLES) * CLK_PERIOD;

	logic          clk_fpga = 1'b0;
	logic          reset_logic;
	logic          i_start;
	logic          i_param_ready;
	param_beat_t   o_param;
	logic          o_param_valid;
	stage_header_t o_header;
	logic          o_stage_done;
	logic          o_busy;

	logic [WORD_WIDTH-1:0] model_mem [NUM_DATABASE_WORDS];
	int                    beat_count        = 0;
	int                    fetches_done      = 0;
	int                    edges_since_start = 0;
	logic                  waiting_first     = 1'b0;
	logic                  done_prev         = 1'b0;
	logic                  fetch_start       = 1'b0;

	haar_stage_fetch_top u_dut (
		.clk_fpga      (clk_fpga),
		.reset_logic   (reset_logic),
		.i_start       (i_start),
		.i_param_ready (i_param_ready),
		.o_param       (o_param),
		.o_param_valid (o_param_valid),
		.o_header      (o_header),
		.o_stage_done  (o_stage_done),
		.o_busy        (o_busy)
	);

	bind haar_stage_fetch_top haar_stage_fetch_properties u_properties (
		.clk_fpga      (clk_fpga),
		.reset_logic   (reset_logic),
		.i_start       (i_start),
		.i_param_ready (i_param_ready),
		.o_param       (o_param),
		.o_param_valid (o_param_valid),
		.o_header      (o_header),
		.o_stage_done  (o_stage_done),
		.o_busy        (o_busy)
	);

	always
	begin
		#(CLK_PERIOD / 2) clk_fpga = ~clk_fpga;
	end

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual);
		abort_run();
	endtask

	task automatic report_failure(input string reason);
		$display("Error: %s", reason);
		abort_run();
	endtask

	// Expected indices follow from the database layout alone.
	task automatic check_beat(input param_beat_t beat, input int expected_index);
		int expected_param;
		int expected_tree;
		expected_param = expected_index % NUM_PARAMS_PER_CLASSIFIER;
		expected_tree  = expected_index / NUM_PARAMS_PER_CLASSIFIER;
		assert (expected_index < NUM_PARAM_WORDS)
		else report_failure("A beat transferred after the last classifier parameter");
		assert (beat.index_database == INDEX_WIDTH'(expected_index))
		else report_mismatch("o_param.index_database", 32'(expected_index),
			32'(beat.index_database));
		assert (beat.data == model_mem[expected_index])
		else report_mismatch("o_param.data", 32'(model_mem[expected_index]), 32'(beat.data));
		assert (beat.index_param == INDEX_WIDTH'(expected_param))
		else report_mismatch("o_param.index_param", 32'(expected_param), 32'(beat.index_param));
		assert (beat.index_tree == INDEX_WIDTH'(expected_tree))
		else report_mismatch("o_param.index_tree", 32'(expected_tree), 32'(beat.index_tree));
		assert (beat.last_param == (expected_param == NUM_PARAMS_PER_CLASSIFIER - 1))
		else report_mismatch("o_param.last_param",
			32'(expected_param == NUM_PARAMS_PER_CLASSIFIER - 1), 32'(beat.last_param));
		assert (beat.last_tree == (expected_index == NUM_PARAM_WORDS - 1))
		else report_mismatch("o_param.last_tree",
			32'(expected_index == NUM_PARAM_WORDS - 1), 32'(beat.last_tree));
	endtask

	task automatic check_header();
		assert (o_header.threshold == model_mem[NUM_PARAM_WORDS])
		else report_mismatch("o_header.threshold", 32'(model_mem[NUM_PARAM_WORDS]),
			32'(o_header.threshold));
		assert (o_header.parent == model_mem[NUM_PARAM_WORDS + 1])
		else report_mismatch("o_header.parent", 32'(model_mem[NUM_PARAM_WORDS + 1]),
			32'(o_header.parent));
		assert (o_header.next == model_mem[NUM_PARAM_WORDS + 2])
		else report_mismatch("o_header.next", 32'(model_mem[NUM_PARAM_WORDS + 2]),
			32'(o_header.next));
	endtask

	always @(posedge clk_fpga)
	begin
		if (u_dut.u_properties.failure_count != 0)
		begin
			report_failure("A bound property on the DUT ports failed");
		end
		if (!reset_logic)
		begin
			if (waiting_first)
			begin
				edges_since_start++;
				if (o_param_valid)
				begin
					// Valid rises on the latency edge and shows up one sample later.
					assert (edges_since_start == FIRST_VALID_LATENCY + 1)
					else report_mismatch("first o_param_valid latency",
						32'(FIRST_VALID_LATENCY), 32'(edges_since_start - 1));
					waiting_first = 1'b0;
				end
			end
			if (o_param_valid && i_param_ready)
			begin
				check_beat(o_param, beat_count);
				beat_count++;
			end
			if (o_stage_done)
			begin
				assert (beat_count == NUM_PARAM_WORDS)
				else report_failure("o_stage_done high before every parameter transferred");
				if (!done_prev)
				begin
					check_header();
					fetches_done++;
				end
			end
			done_prev = o_stage_done;
			// Only the fetch's own start pulse restarts the expected sequence.
			if (fetch_start)
			begin
				beat_count        = 0;
				edges_since_start = 0;
				waiting_first     = 1'b1;
			end
		end
	end

	// Called just after a rising edge; returns on the edge where done is seen.
	task automatic run_fetch(input logic random_ready);
		int cycle;
		i_start       <= 1'b1;
		fetch_start   <= 1'b1;
		i_param_ready <= 1'b1;
		@(posedge clk_fpga);
		i_start     <= 1'b0;
		fetch_start <= 1'b0;
		@(posedge clk_fpga);
		cycle = 0;
		while (!o_stage_done)
		begin
			// These starts land while busy and must be ignored.
			i_start       <= (cycle == 8) || (cycle == 20);
			i_param_ready <= random_ready ? (($urandom % 4) != 0) : 1'b1;
			cycle++;
			@(posedge clk_fpga);
		end
		i_start <= 1'b0;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		report_failure("Watchdog expired before both stage fetches completed");
	end

	initial
	begin
		void'($urandom(RANDOM_SEED));
		$readmemh(DATABASE_FILE, model_mem);
		reset_logic   <= 1'b1;
		i_start       <= 1'b0;
		i_param_ready <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_fpga);
		reset_logic <= 1'b0;
		@(posedge clk_fpga);
		assert (!o_param_valid) else report_mismatch("o_param_valid", 32'h0, 32'(o_param_valid));
		assert (!o_busy) else report_mismatch("o_busy", 32'h0, 32'(o_busy));
		assert (!o_stage_done) else report_mismatch("o_stage_done", 32'h0, 32'(o_stage_done));
		run_fetch(1'b0);
		repeat (4) @(posedge clk_fpga);
		run_fetch(1'b1);
		repeat (4) @(posedge clk_fpga);
		assert (fetches_done == 2)
		else report_mismatch("completed stage fetches", 32'd2, 32'(fetches_done));
		if (u_dut.u_properties.failure_count != 0)
		begin
			report_failure("A bound property on the DUT ports failed");
		end
		else
		begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// File: stage_database.mem
// One 12-bit hex word per line: 38 classifier parameters (2 trees x 19),
// then the stage threshold, parent link and next link.
3a1
0c7
5f2
e18
244
9b3
71d
0e5
c6a
38f
a02
4d9
f36
15c
87b
2e0
b94
6c1
d3e
057
9a8
e6f
312
c0d
4b6
7f9
1a3
8e4
d51
26a
f0c
5b7
a38
09e
6d5
b20
47b
e93
1f4
3ff
001

// File: all.f
source/haar_stage_pkg.sv
source/stage_rom.sv
source/stage_param_streamer.sv
source/stage_header_regs.sv
source/haar_stage_fetch_top.sv
sim/haar_stage_fetch_properties.sv
sim/tb_haar_stage_fetch.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_haar_stage_fetch
FILELIST   = all.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation failed
PASS_MSG   = Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
